/* include/decode_config.svh */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// ====================
// Datapath widths
// ====================

// Data and PC width
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// ====================
// Stage shape
// ====================

`define LANES 2
`define WB_PORTS 2

`endif

/* rtl/decode_pkg.sv */
`default_nettype none

`include "decode_config.svh"

package decode_pkg;

    // Supported major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // Register-type field layout
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fields_t;

    // Store-type field layout, immediate split around the sources
    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } s_fields_t;

    typedef union packed {
        r_fields_t r_view;
        s_fields_t s_view;
    } instr_word_u;

    // Control word carried with each dispatched instruction
    typedef struct packed {
        logic [3:0] alu_op;
        logic       use_imm;
        logic       reg_write;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
    } ctrl_t;

endpackage

`default_nettype wire

/* rtl/decode_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_config.svh"

// Combinational read path, two sources per lane
interface rf_read_if;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    modport lane (
        output rs1_addr, rs2_addr,
        input  rs1_data, rs2_data
    );

    modport rf (
        input  rs1_addr, rs2_addr,
        output rs1_data, rs2_data
    );
endinterface

// Write request with valid/ready handshake
interface rf_write_if;
    logic                   valid;
    logic                   ready;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`XLEN-1:0]       data;

    // Writeback source as seen by the arbiter
    modport arb_in  (input valid, addr, data, output ready);
    // Granted request towards the register file
    modport arb_out (output valid, addr, data, input ready);
    modport rf      (input valid, addr, data, output ready);
endinterface

`default_nettype wire

/* rtl/instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_config.svh"

module instr_decoder (
    input  decode_pkg::instr_word_u   instr_i,
    output logic [`REG_ADDR_W-1:0]    rs1_o,
    output logic [`REG_ADDR_W-1:0]    rs2_o,
    output logic [`REG_ADDR_W-1:0]    rd_o,
    output decode_pkg::ctrl_t         ctrl_o,
    output logic [`XLEN-1:0]          imm_o
);
    import decode_pkg::*;

    logic [`XLEN-1:0] imm_i_form;
    logic [`XLEN-1:0] imm_s_form;
    logic [`XLEN-1:0] imm_b_form;
    logic             sign;

    // ====================
    // Field extraction
    // ====================

    assign rs1_o = instr_i.r_view.rs1;
    assign rs2_o = instr_i.r_view.rs2;
    assign sign  = instr_i.r_view.funct7[6];

    // I form sits in funct7 and rs2 of the R layout
    assign imm_i_form = {{(`XLEN-12){sign}}, instr_i.r_view.funct7, instr_i.r_view.rs2};

    assign imm_s_form = {{(`XLEN-12){sign}}, instr_i.s_view.imm_hi, instr_i.s_view.imm_lo};

    // B form reuses the S fields with bit 11 moved down to imm_lo[0]
    assign imm_b_form = {{(`XLEN-13){sign}}, instr_i.s_view.imm_hi[6], instr_i.s_view.imm_lo[0],
                         instr_i.s_view.imm_hi[5:0], instr_i.s_view.imm_lo[4:1], 1'b0};

    // ====================
    // Control and immediate
    // ====================

    always_comb begin
        ctrl_o = '0;
        imm_o  = '0;
        case (instr_i.r_view.opcode)
            OPC_OP: begin
                ctrl_o.alu_op    = {instr_i.r_view.funct3, instr_i.r_view.funct7[5]};
                ctrl_o.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.reg_write = 1'b1;
                imm_o            = imm_i_form;
            end
            OPC_LOAD: begin
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.is_load   = 1'b1;
                imm_o            = imm_i_form;
            end
            OPC_STORE: begin
                ctrl_o.use_imm  = 1'b1;
                ctrl_o.is_store = 1'b1;
                imm_o           = imm_s_form;
            end
            // Branch compares rs1 with rs2, offset rides along as immediate
            OPC_BRANCH: begin
                ctrl_o.is_branch = 1'b1;
                imm_o            = imm_b_form;
            end
            default: begin
                ctrl_o = '0;
                imm_o  = '0;
            end
        endcase
    end

    // No destination unless the instruction writes back
    assign rd_o = ctrl_o.reg_write ? instr_i.r_view.rd : '0;

endmodule

`default_nettype wire

/* rtl/decode_lane.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_config.svh"

module decode_lane (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush_i,
    input  logic                     bubble_i,
    input  logic                     in_valid_i,
    input  decode_pkg::instr_word_u  instr_i,
    input  logic [`XLEN-1:0]         pc_i,
    output logic                     dec_ready_o,
    rf_read_if.lane                  rd_port,
    input  logic                     dispatch_ready_i,
    output logic                     disp_valid_o,
    output decode_pkg::ctrl_t        disp_ctrl_o,
    output logic [`XLEN-1:0]         disp_pc_o,
    output logic [`XLEN-1:0]         disp_op_a_o,
    output logic [`XLEN-1:0]         disp_op_b_o,
    output logic [`XLEN-1:0]         disp_store_data_o,
    output logic [`REG_ADDR_W-1:0]   disp_rd_o
);
    import decode_pkg::*;

    ctrl_t                  dec_ctrl;
    logic [`REG_ADDR_W-1:0] dec_rd;
    logic [`XLEN-1:0]       dec_imm;
    logic [`XLEN-1:0]       op_b_mux;
    logic                   accept;

    instr_decoder u_decoder (
        .instr_i (instr_i),
        .rs1_o   (rd_port.rs1_addr),
        .rs2_o   (rd_port.rs2_addr),
        .rd_o    (dec_rd),
        .ctrl_o  (dec_ctrl),
        .imm_o   (dec_imm)
    );

    // Operand B is the immediate or the second source
    assign op_b_mux = dec_ctrl.use_imm ? dec_imm : rd_port.rs2_data;

    // ====================
    // Handshake
    // ====================

    // Slot can take a new entry when it drains or is empty
    assign dec_ready_o = (dispatch_ready_i | ~disp_valid_o) & ~flush_i & ~bubble_i;
    assign accept      = in_valid_i & dec_ready_o;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            disp_valid_o <= 1'b0;
        end else if (flush_i) begin
            disp_valid_o <= 1'b0;
        end else if (accept) begin
            disp_valid_o <= 1'b1;
        end else if (dispatch_ready_i) begin
            // Slot taken with nothing behind it
            disp_valid_o <= 1'b0;
        end
    end

    // Payload only moves on acceptance, so a held slot keeps its contents
    always_ff @(posedge clk) begin
        if (accept) begin
            disp_ctrl_o       <= dec_ctrl;
            disp_pc_o         <= pc_i;
            disp_op_a_o       <= rd_port.rs1_data;
            disp_op_b_o       <= op_b_mux;
            disp_store_data_o <= rd_port.rs2_data;
            disp_rd_o         <= dec_rd;
        end
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_config.svh"

module reg_file (
    input  logic    clk,
    input  logic    reset,
    rf_read_if.rf   rd_a,
    rf_read_if.rf   rd_b,
    rf_write_if.rf  wr
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wr_fire;

    // Single write port never stalls
    assign wr.ready = 1'b1;
    assign wr_fire  = wr.valid & wr.ready;

    // x0 reads zero, a same-cycle write to the register is passed straight through
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_W-1:0] addr);
        logic [`XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_fire && (wr.addr == addr)) begin
            value = wr.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // ====================
    // Read ports
    // ====================

    assign rd_a.rs1_data = read_reg(rd_a.rs1_addr);
    assign rd_a.rs2_data = read_reg(rd_a.rs2_addr);
    assign rd_b.rs1_data = read_reg(rd_b.rs1_addr);
    assign rd_b.rs2_data = read_reg(rd_b.rs2_addr);

    // ====================
    // Write port
    // ====================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

endmodule

`default_nettype wire

/* rtl/wb_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_arbiter (
    rf_write_if.arb_in   src0,
    rf_write_if.arb_in   src1,
    rf_write_if.arb_out  dst
);

    logic grant1;

    // Source 0 wins whenever it asks
    assign grant1 = ~src0.valid;

    // ====================
    // Request path
    // ====================

    assign dst.valid = src0.valid | src1.valid;
    assign dst.addr  = grant1 ? src1.addr : src0.addr;
    assign dst.data  = grant1 ? src1.data : src0.data;

    // ====================
    // Ready return
    // ====================

    assign src0.ready = dst.ready;
    // Source 1 waits while source 0 is requesting
    assign src1.ready = dst.ready & grant1;

endmodule

`default_nettype wire

/* rtl/decode_stage_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_config.svh"

module decode_stage_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush_i,
    input  logic                     bubble_i,
    input  logic [`LANES-1:0]        in_valid_i,
    input  decode_pkg::instr_word_u  instr_i [`LANES],
    input  logic [`XLEN-1:0]         pc_i [`LANES],
    output logic [`LANES-1:0]        dec_ready_o,
    input  logic [`LANES-1:0]        dispatch_ready_i,
    output logic [`LANES-1:0]        disp_valid_o,
    output decode_pkg::ctrl_t        disp_ctrl_o [`LANES],
    output logic [`XLEN-1:0]         disp_pc_o [`LANES],
    output logic [`XLEN-1:0]         disp_op_a_o [`LANES],
    output logic [`XLEN-1:0]         disp_op_b_o [`LANES],
    output logic [`XLEN-1:0]         disp_store_data_o [`LANES],
    output logic [`REG_ADDR_W-1:0]   disp_rd_o [`LANES],
    input  logic [`WB_PORTS-1:0]     wb_valid_i,
    input  logic [`REG_ADDR_W-1:0]   wb_rd_i [`WB_PORTS],
    input  logic [`XLEN-1:0]         wb_data_i [`WB_PORTS],
    output logic [`WB_PORTS-1:0]     wb_ready_o
);

    rf_read_if  rd_if [`LANES] ();
    rf_write_if wb_if [`WB_PORTS] ();
    rf_write_if rf_wr_if ();

    // ====================
    // Decode lanes
    // ====================

    for (genvar g = 0; g < `LANES; g++) begin : g_lane
        decode_lane u_lane (
            .clk               (clk),
            .reset             (reset),
            .flush_i           (flush_i),
            .bubble_i          (bubble_i),
            .in_valid_i        (in_valid_i[g]),
            .instr_i           (instr_i[g]),
            .pc_i              (pc_i[g]),
            .dec_ready_o       (dec_ready_o[g]),
            .rd_port           (rd_if[g]),
            .dispatch_ready_i  (dispatch_ready_i[g]),
            .disp_valid_o      (disp_valid_o[g]),
            .disp_ctrl_o       (disp_ctrl_o[g]),
            .disp_pc_o         (disp_pc_o[g]),
            .disp_op_a_o       (disp_op_a_o[g]),
            .disp_op_b_o       (disp_op_b_o[g]),
            .disp_store_data_o (disp_store_data_o[g]),
            .disp_rd_o         (disp_rd_o[g])
        );
    end

    // Writeback sources enter through plain ports
    for (genvar w = 0; w < `WB_PORTS; w++) begin : g_wb
        assign wb_if[w].valid = wb_valid_i[w];
        assign wb_if[w].addr  = wb_rd_i[w];
        assign wb_if[w].data  = wb_data_i[w];
        assign wb_ready_o[w]  = wb_if[w].ready;
    end

    // ====================
    // Shared register file
    // ====================

    wb_arbiter u_arbiter (
        .src0 (wb_if[0]),
        .src1 (wb_if[1]),
        .dst  (rf_wr_if)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .rd_a  (rd_if[0]),
        .rd_b  (rd_if[1]),
        .wr    (rf_wr_if)
    );

endmodule

`default_nettype wire

/* tb/decode_tb_model.svh */
`ifndef DECODE_TB_MODEL_SVH
`define DECODE_TB_MODEL_SVH

// ====================
// Reference state
// ====================

logic [`XLEN-1:0]       model_regs [`REG_COUNT];
logic [`LANES-1:0]      exp_valid;
// Control bits {alu_op, use_imm, reg_write, is_load, is_store, is_branch}
logic [8:0]             exp_ctrl [`LANES];
logic [`XLEN-1:0]       exp_pc [`LANES];
logic [`XLEN-1:0]       exp_op_a [`LANES];
logic [`XLEN-1:0]       exp_op_b [`LANES];
logic [`XLEN-1:0]       exp_store [`LANES];
logic [`REG_ADDR_W-1:0] exp_rd [`LANES];

function automatic logic [8:0] expected_ctrl(input logic [31:0] w);
    case (w[6:0])
        7'b0110011: return {w[14:12], w[30], 5'b01000};
        7'b0010011: return {4'b0000, 5'b11000};
        7'b0000011: return {4'b0000, 5'b11100};
        7'b0100011: return {4'b0000, 5'b10010};
        7'b1100011: return {4'b0000, 5'b00001};
        default:    return '0;
    endcase
endfunction

// Sign-extended I, S and B immediates straight from the instruction bits
function automatic logic [`XLEN-1:0] expected_imm(input logic [31:0] w);
    case (w[6:0])
        7'b0010011, 7'b0000011: return {{20{w[31]}}, w[31:20]};
        7'b0100011: return {{20{w[31]}}, w[31:25], w[11:7]};
        7'b1100011: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        default:    return '0;
    endcase
endfunction

function automatic logic expected_ready(input int n);
    return (dispatch_ready[n] | ~exp_valid[n]) & ~flush & ~bubble;
endfunction

// Register read with the granted write of the same cycle passed through
function automatic logic [`XLEN-1:0] expected_read(input logic [`REG_ADDR_W-1:0] addr,
                                                   input logic wr_v,
                                                   input logic [`REG_ADDR_W-1:0] wr_a,
                                                   input logic [`XLEN-1:0] wr_d);
    if (addr == '0) begin
        return '0;
    end else if (wr_v && (wr_a == addr)) begin
        return wr_d;
    end
    return model_regs[addr];
endfunction

task automatic model_reset();
    for (int i = 0; i < `REG_COUNT; i++) begin
        model_regs[i] = '0;
    end
    exp_valid = '0;
endtask

// Applies one rising edge to the model using the inputs now on the DUT
task automatic model_advance();
    logic                   wr_v;
    logic [`REG_ADDR_W-1:0] wr_a;
    logic [`XLEN-1:0]       wr_d;
    logic [31:0]            w;
    // Source 0 first
    wr_v = wb_valid[0] | wb_valid[1];
    wr_a = wb_valid[0] ? wb_rd[0] : wb_rd[1];
    wr_d = wb_valid[0] ? wb_data[0] : wb_data[1];
    for (int n = 0; n < `LANES; n++) begin
        w = instr[n];
        if (flush) begin
            exp_valid[n] = 1'b0;
        end else if (in_valid[n] && expected_ready(n)) begin
            exp_valid[n] = 1'b1;
            exp_ctrl[n]  = expected_ctrl(w);
            exp_pc[n]    = pc[n];
            exp_op_a[n]  = expected_read(w[19:15], wr_v, wr_a, wr_d);
            exp_store[n] = expected_read(w[24:20], wr_v, wr_a, wr_d);
            exp_op_b[n]  = exp_ctrl[n][4] ? expected_imm(w) : exp_store[n];
            exp_rd[n]    = exp_ctrl[n][3] ? w[11:7] : '0;
        end else if (dispatch_ready[n]) begin
            exp_valid[n] = 1'b0;
        end
    end
    if (wr_v && (wr_a != '0)) begin
        model_regs[wr_a] = wr_d;
    end
endtask

`endif

/* tb/tb_decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_config.svh"

module tb_decode_stage;
    import decode_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int TEST_CYCLES  = 2000;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   flush;
    logic                   bubble;
    logic [`LANES-1:0]      in_valid;
    instr_word_u            instr [`LANES];
    logic [`XLEN-1:0]       pc [`LANES];
    logic [`LANES-1:0]      dec_ready;
    logic [`LANES-1:0]      dispatch_ready;
    logic [`LANES-1:0]      disp_valid;
    ctrl_t                  disp_ctrl [`LANES];
    logic [`XLEN-1:0]       disp_pc [`LANES];
    logic [`XLEN-1:0]       disp_op_a [`LANES];
    logic [`XLEN-1:0]       disp_op_b [`LANES];
    logic [`XLEN-1:0]       disp_store_data [`LANES];
    logic [`REG_ADDR_W-1:0] disp_rd [`LANES];
    logic [`WB_PORTS-1:0]   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd [`WB_PORTS];
    logic [`XLEN-1:0]       wb_data [`WB_PORTS];
    logic [`WB_PORTS-1:0]   wb_ready;
    integer                 seed = 58;
    int                     error_count = 0;

    `include "decode_tb_model.svh"

    decode_stage_top dut_i (
        .clk(clk), .reset(reset), .flush_i(flush), .bubble_i(bubble),
        .in_valid_i(in_valid), .instr_i(instr), .pc_i(pc), .dec_ready_o(dec_ready),
        .dispatch_ready_i(dispatch_ready), .disp_valid_o(disp_valid),
        .disp_ctrl_o(disp_ctrl), .disp_pc_o(disp_pc), .disp_op_a_o(disp_op_a),
        .disp_op_b_o(disp_op_b), .disp_store_data_o(disp_store_data), .disp_rd_o(disp_rd),
        .wb_valid_i(wb_valid), .wb_rd_i(wb_rd), .wb_data_i(wb_data), .wb_ready_o(wb_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic roll(input int pct);
        logic [31:0] r;
        r = rand_word();
        return (r % 32'd100) < 32'(pct);
    endfunction

    // Mostly supported opcodes and a few that decode to nothing
    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        logic [31:0] r;
        w = rand_word();
        r = rand_word();
        case (r[2:0])
            3'd0: w[6:0] = 7'b0000011;
            3'd1: w[6:0] = 7'b0010011;
            3'd2: w[6:0] = 7'b0100011;
            3'd3: w[6:0] = 7'b0110011;
            3'd4: w[6:0] = 7'b1100011;
            3'd5: w[6:0] = 7'b0110111;
            3'd6: w[6:0] = 7'b1101111;
            default: w[6:0] = 7'b0000000;
        endcase
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("FAILED at %0t ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_outputs();
        for (int n = 0; n < `LANES; n++) begin
            check_value($sformatf("dec_ready_o[%0d]", n), 32'(expected_ready(n)),
                        32'(dec_ready[n]));
            check_value($sformatf("disp_valid_o[%0d]", n), 32'(exp_valid[n]),
                        32'(disp_valid[n]));
            if (exp_valid[n]) begin
                check_value($sformatf("disp_ctrl_o[%0d]", n), 32'(exp_ctrl[n]),
                            32'(disp_ctrl[n]));
                check_value($sformatf("disp_pc_o[%0d]", n), exp_pc[n], disp_pc[n]);
                check_value($sformatf("disp_op_a_o[%0d]", n), exp_op_a[n], disp_op_a[n]);
                check_value($sformatf("disp_op_b_o[%0d]", n), exp_op_b[n], disp_op_b[n]);
                check_value($sformatf("disp_store_data_o[%0d]", n), exp_store[n],
                            disp_store_data[n]);
                check_value($sformatf("disp_rd_o[%0d]", n), 32'(exp_rd[n]), 32'(disp_rd[n]));
            end
        end
        // Source 1 only gets the port while source 0 is idle
        check_value("wb_ready_o[0]", 32'd1, 32'(wb_ready[0]));
        check_value("wb_ready_o[1]", 32'(!wb_valid[0]), 32'(wb_ready[1]));
    endtask

    // ====================
    // Stimulus
    // ====================

    task automatic drive_inputs();
        logic [`WB_PORTS-1:0]   v;
        logic [`REG_ADDR_W-1:0] a [`WB_PORTS];
        logic [31:0]            w;
        logic [31:0]            r;
        v = wb_valid;
        for (int p = 0; p < `WB_PORTS; p++) begin
            a[p] = wb_rd[p];
            // A refused source 1 keeps its request unchanged
            if (!((p == 1) && wb_valid[0] && wb_valid[1])) begin
                w = rand_word();
                v[p] = roll(50);
                a[p] = w[4:0];
                wb_rd[p] <= w[4:0];
                wb_data[p] <= rand_word();
            end
        end
        wb_valid <= v;
        for (int n = 0; n < `LANES; n++) begin
            w = random_instr();
            r = rand_word();
            // Steer some sources onto the registers being written
            if (r[1:0] == 2'b00) w[19:15] = a[0];
            if (r[3:2] == 2'b00) w[24:20] = a[1];
            instr[n] <= w;
            pc[n] <= {r[31:2], 2'b00};
            in_valid[n] <= roll(70);
            dispatch_ready[n] <= roll(60);
        end
        flush <= roll(4);
        bubble <= roll(8);
    endtask

    initial begin
        reset <= 1'b0;
        flush <= 1'b0;
        bubble <= 1'b0;
        in_valid <= '0;
        dispatch_ready <= '0;
        wb_valid <= '0;
        for (int n = 0; n < `LANES; n++) begin
            instr[n] <= '0;
            pc[n] <= '0;
        end
        for (int p = 0; p < `WB_PORTS; p++) begin
            wb_rd[p] <= '0;
            wb_data[p] <= '0;
        end
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
        // Check mid-cycle, then let the edge land and drive the next inputs
        for (int c = 0; c < TEST_CYCLES; c++) begin
            @(negedge clk);
            check_outputs();
            model_advance();
            @(posedge clk);
            drive_inputs();
        end
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + 10) * CLK_PERIOD);
        $display("Timeout: the test did not finish in the expected time");
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
+incdir+tb
rtl/decode_pkg.sv
rtl/decode_ifs.sv
rtl/instr_decoder.sv
rtl/decode_lane.sv
rtl/reg_file.sv
rtl/wb_arbiter.sv
rtl/decode_stage_top.sv
tb/tb_decode_stage.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_decode_stage
FILELIST = src.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
